// ==== verilog/ifu_cfg_pkg.sv ====
`default_nettype none

package ifu_cfg_pkg;

   // **************************************************
   // Fetch start and predictor geometry
   // **************************************************
   localparam logic [31:0] reset_pc    = 32'h0000_1000;          // Byte address of first fetch
   localparam int          btb_entries = 16;                     // Direct mapped
   localparam int          btb_idx_w   = $clog2(btb_entries);    // PC[5:2]
   localparam int          btb_tag_w   = 32 - btb_idx_w - 2;     // PC[31:6]

   // **************************************************
   // Bus side and queue sizing
   // **************************************************
   localparam int          max_outstanding = 4;                  // AR accepted, R not yet seen
   localparam int          iq_depth        = 8;                  // Instruction queue entries
   localparam int          bus_id_w        = 2;
   localparam logic [1:0]  resp_okay       = 2'b00;
   localparam logic [2:0]  ar_size_word    = 3'b010;             // 4 bytes per beat
   localparam logic [1:0]  ar_burst_incr   = 2'b01;

   // Counter widths derived from the sizes above
   localparam int          req_cnt_w = $clog2(max_outstanding + 1);
   localparam int          iq_cnt_w  = $clog2(iq_depth + 1);
   localparam int          credit_w  = $clog2(iq_depth + max_outstanding + 1);

endpackage

`default_nettype wire

// ==== verilog/ifu_types_pkg.sv ====
`default_nettype none

package ifu_types_pkg;

   // **************************************************
   // Request record, one per accepted AR
   // **************************************************
   typedef struct packed {
      logic [31:1] pc;          // Fetch address, halfword granular
      logic        pred_taken;  // BTB hit when the AR went out
      logic        epoch;       // Flush epoch the read belongs to
   } fetch_req_t;

   // **************************************************
   // Instruction record handed to decode
   // **************************************************
   typedef struct packed {
      logic [31:1] pc;          // PC of this instruction
      logic [31:0] instr;       // Raw word from R channel
      logic        pred_taken;  // Next PC came from the BTB
      logic        fault;       // Bus error on the fetch
   } fetch_instr_t;

   // Both records are flopped whole inside ifu_queue
   // and split back into fields where they are consumed.
   // PC bit 0 is never stored, as in the rest of the core.
   // The epoch bit only has to tell the current flush
   // period apart from the one before it.

endpackage

`default_nettype wire

// ==== verilog/ifu_queue.sv ====
`default_nettype none

module ifu_queue #(
   parameter type payload_t = logic,
   parameter int  depth     = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clear,      // Drop all entries this cycle
   input  logic                       push,
   input  payload_t                   push_data,
   input  logic                       pop,
   output payload_t                   pop_data,   // Head entry
   output logic                       not_empty,
   output logic [$clog2(depth+1)-1:0] count       // Entries held
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];                 // Storage array
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign not_empty = (count != '0);
   assign pop_data  = mem[rd_ptr];
   assign do_pop    = pop & not_empty;                                  // Ignore pop on empty
   assign do_push   = push & ((count < cnt_w'(depth)) | do_pop);        // Full blocks push

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst | clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;   // Wrap
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

   // Data array, written at the tail
   always_ff @(posedge clk) begin
      if (do_push & ~clear) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ifu_btb.sv ====
`default_nettype none

module ifu_btb
   import ifu_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [31:1] lookup_pc,      // PC of the AR being presented
   input  logic        upd_valid,      // Resolved branch from execute
   input  logic [31:1] upd_pc,
   input  logic [31:1] upd_target,
   input  logic        upd_taken,
   input  logic        bpred_disable,  // Force all lookups to miss
   output logic        hit,
   output logic [31:1] target
);

   logic [btb_entries-1:0] valid_q;                // One per entry
   logic [btb_tag_w-1:0]   tag_q [btb_entries];
   logic [31:1]            tgt_q [btb_entries];

   logic [btb_idx_w-1:0]   rd_idx;
   logic [btb_tag_w-1:0]   rd_tag;
   logic [btb_idx_w-1:0]   wr_idx;
   logic [btb_tag_w-1:0]   wr_tag;
   logic                   wr_alloc;               // Taken update
   logic                   wr_kill;                // Not taken, tag matches

   // **************************************************
   // Lookup
   // **************************************************
   assign rd_idx = lookup_pc[btb_idx_w+1:2];       // Word index
   assign rd_tag = lookup_pc[31:btb_idx_w+2];

   assign hit    = valid_q[rd_idx] & (tag_q[rd_idx] == rd_tag) & ~bpred_disable;
   assign target = tgt_q[rd_idx];

   // **************************************************
   // Update from execute
   // **************************************************
   assign wr_idx   = upd_pc[btb_idx_w+1:2];
   assign wr_tag   = upd_pc[31:btb_idx_w+2];
   assign wr_alloc = upd_valid & upd_taken;
   assign wr_kill  = upd_valid & ~upd_taken & (tag_q[wr_idx] == wr_tag);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;                            // Empty after reset
      end else if (wr_alloc) begin
         valid_q[wr_idx] <= 1'b1;
      end else if (wr_kill) begin
         valid_q[wr_idx] <= 1'b0;                  // Stop predicting this branch
      end
   end

   // Tag and target only change on allocation
   always_ff @(posedge clk) begin
      if (wr_alloc) begin
         tag_q[wr_idx] <= wr_tag;
         tgt_q[wr_idx] <= upd_target;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ifu_fetch_ctl.sv ====
`default_nettype none

module ifu_fetch_ctl
   import ifu_cfg_pkg::*;
   import ifu_types_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic [31:1]         flush_pc,
   input  logic                btb_hit,
   input  logic [31:1]         btb_target,
   input  logic                arready,
   input  logic                rvalid,
   input  logic [bus_id_w-1:0] rid,
   input  logic [31:0]         rdata,
   input  logic [1:0]          rresp,
   input  logic [iq_cnt_w-1:0] iq_count,   // Instruction queue occupancy
   output logic [31:1]         lookup_pc,  // To BTB
   output logic                arvalid,
   output logic [31:0]         araddr,
   output logic [bus_id_w-1:0] arid,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output logic [1:0]          arburst,
   output logic                rready,
   output logic                iq_push,
   output fetch_instr_t        iq_data
);

   logic                 arvalid_q;
   logic [31:1]          araddr_q;       // Address of AR on the bus
   logic                 ar_stale_q;     // Held AR overtaken by a flush
   logic [31:1]          next_pc_q;      // Start of next new AR
   logic                 epoch_q;        // Current flush epoch
   logic                 ar_fire;
   logic                 ar_hold;        // AR waiting on arready
   logic                 r_fire;
   logic [31:1]          pred_pc;
   logic [31:1]          nxt_pc;
   logic                 nxt_epoch;
   logic                 req_epoch;
   logic [credit_w-1:0]  out_after;      // Outstanding after this cycle
   logic [credit_w-1:0]  used_after;     // Plus queue occupancy
   logic                 can_issue;
   fetch_req_t           req_in;
   fetch_req_t           req_head;
   logic                 req_not_empty;
   logic [req_cnt_w-1:0] req_count;
   logic                 resp_bad;

   // **************************************************
   // Next PC and epoch
   // **************************************************
   assign ar_fire   = arvalid_q & arready;
   assign ar_hold   = arvalid_q & ~arready;
   assign lookup_pc = araddr_q;
   assign pred_pc   = btb_hit ? btb_target : araddr_q + 31'd2;   // +4 bytes
   // A stale AR completing must not steer the PC
   assign nxt_pc    = flush                   ? flush_pc :
                      (ar_fire & ~ar_stale_q) ? pred_pc  :
                                                next_pc_q;
   assign nxt_epoch = epoch_q ^ flush;
   // Mark the request with the epoch it can never match if it is dead
   assign req_epoch = (ar_stale_q | flush) ? ~nxt_epoch : nxt_epoch;

   // Credits reserve queue room for every read in flight
   assign out_after  = credit_w'(req_count) + credit_w'(ar_fire);
   assign used_after = out_after + credit_w'(iq_count);
   assign can_issue  = (out_after < credit_w'(max_outstanding)) &
                       (used_after < credit_w'(iq_depth));

   always_ff @(posedge clk) begin
      if (rst) begin
         arvalid_q  <= 1'b0;
         ar_stale_q <= 1'b0;
         epoch_q    <= 1'b0;
         next_pc_q  <= reset_pc[31:1];
      end else begin
         epoch_q   <= nxt_epoch;
         next_pc_q <= nxt_pc;
         if (ar_hold) begin
            ar_stale_q <= ar_stale_q | flush;       // Keep AR, remember the flush
         end else begin
            arvalid_q  <= can_issue;
            ar_stale_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (~ar_hold) begin
         araddr_q <= nxt_pc;                        // Frozen while AR waits
      end
   end

   // **************************************************
   // AR channel
   // **************************************************
   assign arvalid = arvalid_q;
   assign araddr  = {araddr_q, 1'b0};
   assign arid    = '0;                             // Single in-order stream
   assign arlen   = 8'd0;                           // One beat
   assign arsize  = ar_size_word;
   assign arburst = ar_burst_incr;

   // **************************************************
   // Request tracking and R return
   // **************************************************
   assign req_in = '{pc: araddr_q, pred_taken: btb_hit, epoch: req_epoch};

   ifu_queue #(
      .payload_t (fetch_req_t),
      .depth     (max_outstanding)
   ) i_req_q (
      .clk       (clk),
      .rst       (rst),
      .clear     (1'b0),                            // In-flight reads still return
      .push      (ar_fire),
      .push_data (req_in),
      .pop       (r_fire),
      .pop_data  (req_head),
      .not_empty (req_not_empty),
      .count     (req_count)
   );

   assign rready   = 1'b1;                          // Space reserved by credits
   assign r_fire   = rvalid & rready;
   assign resp_bad = (rresp != resp_okay) | (rid != '0);   // Error or unknown ID
   assign iq_push  = r_fire & req_not_empty & (req_head.epoch == epoch_q) & ~flush;
   assign iq_data  = '{pc:         req_head.pc,
                       instr:      rdata,
                       pred_taken: req_head.pred_taken,
                       fault:      resp_bad};

endmodule

`default_nettype wire

// ==== verilog/ifu_top.sv ====
`default_nettype none

module ifu_top
   import ifu_cfg_pkg::*;
   import ifu_types_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,            // Redirect from execute
   input  logic [31:1]         flush_pc,
   input  logic                upd_valid,        // BTB update, with flush
   input  logic [31:1]         upd_pc,
   input  logic [31:1]         upd_target,
   input  logic                upd_taken,
   input  logic                bpred_disable,
   output logic                arvalid,          // AXI read address
   input  logic                arready,
   output logic [31:0]         araddr,
   output logic [bus_id_w-1:0] arid,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output logic [1:0]          arburst,
   input  logic                rvalid,           // AXI read data
   output logic                rready,
   input  logic [bus_id_w-1:0] rid,
   input  logic [31:0]         rdata,
   input  logic [1:0]          rresp,
   output logic                instr_valid,      // To decode
   input  logic                instr_ready,
   output logic [31:0]         instr,
   output logic [31:1]         instr_pc,
   output logic                instr_pred_taken,
   output logic                instr_fault
);

   logic [31:1]         lookup_pc;
   logic                btb_hit;
   logic [31:1]         btb_target;
   logic                iq_push;
   fetch_instr_t        iq_data;
   fetch_instr_t        iq_head;
   logic [iq_cnt_w-1:0] iq_count;

   // **************************************************
   // Fetch control and predictor
   // **************************************************
   ifu_fetch_ctl i_fetch_ctl (
      .clk        (clk),        .rst      (rst),
      .flush      (flush),      .flush_pc (flush_pc),
      .btb_hit    (btb_hit),    .btb_target (btb_target),
      .arready    (arready),    .rvalid   (rvalid),
      .rid        (rid),        .rdata    (rdata),
      .rresp      (rresp),      .iq_count (iq_count),
      .lookup_pc  (lookup_pc),  .arvalid  (arvalid),
      .araddr     (araddr),     .arid     (arid),
      .arlen      (arlen),      .arsize   (arsize),
      .arburst    (arburst),    .rready   (rready),
      .iq_push    (iq_push),    .iq_data  (iq_data)
   );

   ifu_btb i_btb (
      .clk (clk), .rst (rst), .lookup_pc (lookup_pc),
      .upd_valid (upd_valid), .upd_pc (upd_pc), .upd_target (upd_target),
      .upd_taken (upd_taken), .bpred_disable (bpred_disable),
      .hit (btb_hit), .target (btb_target)
   );

   // **************************************************
   // Instruction queue toward decode
   // **************************************************
   ifu_queue #(
      .payload_t (fetch_instr_t),
      .depth     (iq_depth)
   ) i_instr_q (
      .clk (clk), .rst (rst),
      .clear     (flush),                                // Emptied in the flush cycle
      .push      (iq_push),
      .push_data (iq_data),
      .pop       (instr_valid & instr_ready),            // Decode handshake
      .pop_data  (iq_head),
      .not_empty (instr_valid),
      .count     (iq_count)
   );

   assign instr            = iq_head.instr;
   assign instr_pc         = iq_head.pc;
   assign instr_pred_taken = iq_head.pred_taken;
   assign instr_fault      = iq_head.fault;

endmodule

`default_nettype wire

// ==== tb/ifu_mem_model.sv ====
`default_nettype none

module ifu_mem_model
   import ifu_cfg_pkg::*;
#(
   parameter logic [31:0] fault_base = 32'h0000_8000   // Error region starts here
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                ar_stall,     // Random hold-off on arready
   input  logic                r_stall,      // Random gap between R beats
   input  logic                arvalid,
   output logic                arready,
   input  logic [31:0]         araddr,
   output logic                rvalid,
   input  logic                rready,
   output logic [bus_id_w-1:0] rid,
   output logic [31:0]         rdata,
   output logic [1:0]          rresp
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] pending [$];                   // Accepted AR addresses, oldest first

   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rid     = '0;
      rdata   = '0;
      rresp   = resp_okay;
   end

   // **************************************************
   // In-order single-beat read slave
   // **************************************************
   always @(posedge clk) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= '0;
         rresp   <= resp_okay;
         pending.delete();
      end else begin
         if (arvalid && arready) begin
            pending.push_back(araddr);         // Address phase done
         end
         if (rvalid && rready) begin
            void'(pending.pop_front());        // Beat delivered
         end
         arready <= ~ar_stall;
         rid     <= '0;
         if ((pending.size() != 0) && !r_stall) begin
            rvalid <= 1'b1;
            rdata  <= ~pending[0];             // Inverse of byte address
            rresp  <= (pending[0] >= fault_base) ? 2'b10 : resp_okay;   // SLVERR
         end else begin
            rvalid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/ifu_tb.sv ====
`default_nettype none

module ifu_tb import ifu_cfg_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          clk_period   = 4;
   localparam logic [31:0] fault_base   = 32'h0000_8000;
   localparam logic [31:0] branch_pc    = 32'h0000_2040;
   localparam logic [31:0] branch_tgt   = 32'h0000_2020;   // Loops back over 9 words
   localparam int          total_instr  = 210;             // Sum of all accept waits
   localparam int          instr_cycles = 24;              // Generous cycles per instruction
   localparam logic [2:0]  exp_arsize   = 3'b010;          // Four bytes per beat
   localparam logic [1:0]  exp_arburst  = 2'b01;           // INCR

   logic                clk;
   logic                rst;
   logic                flush;
   logic [31:1]         flush_pc;
   logic                upd_valid;
   logic [31:1]         upd_pc;
   logic [31:1]         upd_target;
   logic                upd_taken;
   logic                bpred_disable;
   logic                arvalid;
   logic                arready;
   logic [31:0]         araddr;
   logic [bus_id_w-1:0] arid;
   logic [7:0]          arlen;
   logic [2:0]          arsize;
   logic [1:0]          arburst;
   logic                rvalid;
   logic                rready;
   logic [bus_id_w-1:0] rid;
   logic [31:0]         rdata;
   logic [1:0]          rresp;
   logic                instr_valid;
   logic                instr_ready;
   logic [31:0]         instr;
   logic [31:1]         instr_pc;
   logic                instr_pred_taken;
   logic                instr_fault;
   logic                ar_stall;
   logic                r_stall;

   // Reference model state
   logic [31:0]            lfsr_state = 32'h4b78;
   logic [31:1]            exp_pc;                      // Next PC decode should see
   logic [btb_entries-1:0] ref_valid;
   logic [btb_tag_w-1:0]   ref_tag [btb_entries];
   logic [31:1]            ref_tgt [btb_entries];
   logic [btb_idx_w-1:0]   exp_idx;
   logic [btb_idx_w-1:0]   upd_idx;
   logic                   exp_pred;
   logic [31:0]            exp_instr;
   logic                   exp_fault;
   logic                   accept;
   int                     accepted    = 0;
   int                     outstanding = 0;             // AR done and R pending
   logic                   past_rst    = 1'b0;
   logic                   held_valid  = 1'b0;          // AR waited last cycle
   logic [31:0]            held_addr;

   ifu_top i_dut (.*);

   ifu_mem_model #(.fault_base(fault_base)) i_mem (
      .clk (clk), .rst (rst), .ar_stall (ar_stall), .r_stall (r_stall),
      .arvalid (arvalid), .arready (arready), .araddr (araddr),
      .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata), .rresp (rresp)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // **************************************************
   // Helpers
   // **************************************************
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois taps x^32+x^22+x^2+x+1
   endfunction

   function automatic logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   task automatic stop_failed();
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("CHECK FAILED at %0d ns: %s expected %h actual %h", $time, name, exp, act);
      stop_failed();
   endtask

   task automatic tick(input logic hold_ready);
      @(posedge clk);
      ar_stall    <= take_bit();
      r_stall     <= take_bit();
      instr_ready <= hold_ready ? 1'b0 : take_bit();   // Decode idle when held
   endtask

   task automatic flush_to(input logic [31:0] pc, input logic upd, input logic taken,
                           input logic [31:0] tgt, input logic dis);
      tick(1'b1);                                      // No decode accept in flush cycle
      flush         <= 1'b1;
      flush_pc      <= pc[31:1];
      upd_valid     <= upd;
      upd_pc        <= pc[31:1];
      upd_target    <= tgt[31:1];
      upd_taken     <= taken;
      bpred_disable <= dis;
      tick(1'b0);
      flush         <= 1'b0;
      upd_valid     <= 1'b0;
   endtask

   task automatic wait_accepts(input int n);
      int target;
      target = accepted + n;
      while (accepted < target) begin
         tick(1'b0);
      end
   endtask

   // **************************************************
   // Reference model
   // **************************************************
   assign accept    = instr_valid & instr_ready & ~flush;
   assign exp_idx   = exp_pc[btb_idx_w+1:2];
   assign upd_idx   = upd_pc[btb_idx_w+1:2];
   assign exp_pred  = ref_valid[exp_idx] & (ref_tag[exp_idx] == exp_pc[31:btb_idx_w+2])
                      & ~bpred_disable;
   assign exp_instr = ~{exp_pc, 1'b0};                 // Memory rule
   assign exp_fault = ({exp_pc, 1'b0} >= fault_base);

   always @(posedge clk) begin
      past_rst   <= rst;
      held_valid <= arvalid & ~arready & ~rst;
      held_addr  <= araddr;
      if (rst) begin
         exp_pc      <= reset_pc[31:1];
         ref_valid   <= '0;
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(arvalid & arready) - int'(rvalid & rready);
         if (accept) begin
            accepted <= accepted + 1;
            exp_pc   <= exp_pred ? ref_tgt[exp_idx] : exp_pc + 31'd2;   // Predicted or +4
         end
         if (flush) begin
            exp_pc <= flush_pc;                        // Redirect wins
            if (upd_valid && upd_taken) begin
               ref_valid[upd_idx] <= 1'b1;
               ref_tag[upd_idx]   <= upd_pc[31:btb_idx_w+2];
               ref_tgt[upd_idx]   <= upd_target;
            end else if (upd_valid && (ref_tag[upd_idx] == upd_pc[31:btb_idx_w+2])) begin
               ref_valid[upd_idx] <= 1'b0;             // Branch no longer taken
            end
         end
      end
   end

   // **************************************************
   // Assertions
   // **************************************************
   a_reset_quiet: assert property (@(posedge clk) (rst && past_rst) |-> !(arvalid || instr_valid))
      else report_mismatch("arvalid|instr_valid", 32'd0, 32'($sampled(arvalid || instr_valid)));
   a_pc: assert property (@(posedge clk) disable iff (rst) accept |-> (instr_pc == exp_pc))
      else report_mismatch("instr_pc", {$sampled(exp_pc), 1'b0}, {$sampled(instr_pc), 1'b0});
   a_instr: assert property (@(posedge clk) disable iff (rst) accept |-> (instr == exp_instr))
      else report_mismatch("instr", $sampled(exp_instr), $sampled(instr));
   a_pred: assert property (@(posedge clk) disable iff (rst)
                            accept |-> (instr_pred_taken == exp_pred))
      else report_mismatch("instr_pred_taken", 32'($sampled(exp_pred)),
                           32'($sampled(instr_pred_taken)));
   a_fault: assert property (@(posedge clk) disable iff (rst)
                             accept |-> (instr_fault == exp_fault))
      else report_mismatch("instr_fault", 32'($sampled(exp_fault)), 32'($sampled(instr_fault)));
   a_credit: assert property (@(posedge clk) disable iff (rst) outstanding <= max_outstanding)
      else report_mismatch("outstanding reads", 32'(max_outstanding), 32'($sampled(outstanding)));
   a_ar_hold: assert property (@(posedge clk) disable iff (rst) held_valid |-> arvalid)
      else report_mismatch("arvalid", 32'd1, 32'($sampled(arvalid)));
   a_ar_addr: assert property (@(posedge clk) disable iff (rst)
                               held_valid |-> (araddr == held_addr))
      else report_mismatch("araddr", $sampled(held_addr), $sampled(araddr));
   a_arid: assert property (@(posedge clk) disable iff (rst) arvalid |-> (arid == '0))
      else report_mismatch("arid", 32'd0, 32'($sampled(arid)));
   a_arlen: assert property (@(posedge clk) disable iff (rst) arvalid |-> (arlen == 8'd0))
      else report_mismatch("arlen", 32'd0, 32'($sampled(arlen)));
   a_arsize: assert property (@(posedge clk) disable iff (rst)
                              arvalid |-> (arsize == exp_arsize))
      else report_mismatch("arsize", 32'(exp_arsize), 32'($sampled(arsize)));
   a_arburst: assert property (@(posedge clk) disable iff (rst)
                               arvalid |-> (arburst == exp_arburst))
      else report_mismatch("arburst", 32'(exp_arburst), 32'($sampled(arburst)));
   a_rready: assert property (@(posedge clk) disable iff (rst) rready)
      else report_mismatch("rready", 32'd1, 32'($sampled(rready)));

   // Watchdog
   initial begin
      #(total_instr * instr_cycles * clk_period);
      $display("Watchdog expired: decode did not receive all instructions in time");
      stop_failed();
   end

   // **************************************************
   // Stimulus
   // **************************************************
   initial begin
      rst           = 1'b1;
      flush         = 1'b0;
      flush_pc      = '0;
      upd_valid     = 1'b0;
      upd_pc        = '0;
      upd_target    = '0;
      upd_taken     = 1'b0;
      bpred_disable = 1'b0;
      instr_ready   = 1'b0;
      ar_stall      = 1'b0;
      r_stall       = 1'b0;
      repeat (5) tick(1'b1);
      rst <= 1'b0;
      wait_accepts(40);                                          // Straight line from reset
      flush_to(32'h0000_3000, 1'b0, 1'b0, 32'd0, 1'b0);          // Reads still in flight
      wait_accepts(20);
      flush_to(branch_pc, 1'b1, 1'b1, branch_tgt, 1'b0);         // Taken so a loop forms
      wait_accepts(30);
      flush_to(branch_pc, 1'b1, 1'b0, 32'd0, 1'b0);              // Not taken so the entry dies
      wait_accepts(20);
      flush_to(branch_pc, 1'b1, 1'b1, branch_tgt, 1'b1);         // Allocated but disabled
      wait_accepts(20);
      flush_to(branch_pc, 1'b0, 1'b0, 32'd0, 1'b0);              // Enabled again
      wait_accepts(20);
      flush_to(fault_base - 32'd16, 1'b0, 1'b0, 32'd0, 1'b0);    // Crosses into error region
      wait_accepts(20);
      flush_to(32'h0000_4000, 1'b0, 1'b0, 32'd0, 1'b0);
      repeat (30) tick(1'b1);                                    // Decode stalled until queue fills
      wait_accepts(40);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/ifu_cfg_pkg.sv
verilog/ifu_types_pkg.sv
verilog/ifu_queue.sv
verilog/ifu_btb.sv
verilog/ifu_fetch_ctl.sv
verilog/ifu_top.sv
tb/ifu_mem_model.sv
tb/ifu_tb.sv
